// ==== build.f ====
design/rtc_time_pkg.sv
design/rtc_cmd_pkg.sv
design/rtc_cmd_decode.sv
design/rtc_calendar_counter.sv
design/rtc_alarm_match.sv
design/rtc_top.sv
dv/rtc_tb.sv

// ==== design/rtc_alarm_match.sv ====
`timescale 1ns/1ps

module rtc_alarm_match (
    input  logic                   secclk,
    input  logic                   reset,
    input  logic                   alarm_hour_wr,
    input  logic                   alarm_minute_wr,
    input  logic                   alarm_en_wr,
    input  rtc_cmd_pkg::cmd_data_t alarm_data,
    input  rtc_time_pkg::hour_t    hour,
    input  rtc_time_pkg::minute_t  minute,
    input  rtc_time_pkg::second_t  second,
    output logic                   alarm
);

    rtc_time_pkg::hour_t   alarm_hour;
    rtc_time_pkg::minute_t alarm_minute;
    logic                  alarm_enable;
    logic                  match;

    always_ff @(posedge secclk)
    begin
        if (alarm_hour_wr)
        begin
            alarm_hour <= rtc_time_pkg::hour_t'(alarm_data);
        end
        if (alarm_minute_wr)
        begin
            alarm_minute <= rtc_time_pkg::minute_t'(alarm_data);
        end
    end

    always_ff @(posedge secclk)
    begin
        if (reset)
        begin
            alarm_enable <= 1'b0;
        end
        else if (alarm_en_wr)
        begin
            alarm_enable <= alarm_data[0];
        end
    end

    // second zero lasts a single cycle, so one match gives one strobe
    always_comb
    begin
        match = alarm_enable && (hour == alarm_hour) && (minute == alarm_minute) &&
                (second == 6'd0);
    end

    always_ff @(posedge secclk)
    begin
        if (reset)
        begin
            alarm <= 1'b0;
        end
        else
        begin
            alarm <= match;
        end
    end

endmodule

// ==== design/rtc_calendar_counter.sv ====
`timescale 1ns/1ps

module rtc_calendar_counter #(
    parameter rtc_time_pkg::year_t    reset_year    = 16'd2023,
    parameter rtc_time_pkg::month_t   reset_month   = 4'd5,
    parameter rtc_time_pkg::day_t     reset_day     = 5'd9,
    parameter rtc_time_pkg::hour_t    reset_hour    = 5'd11,
    parameter rtc_time_pkg::minute_t  reset_minute  = 6'd59,
    parameter rtc_time_pkg::second_t  reset_second  = 6'd58,
    parameter rtc_time_pkg::weekday_t reset_weekday = 3'd2
) (
    input  logic                   secclk,
    input  logic                   reset,
    input  logic                   load_strobe,
    input  rtc_time_pkg::year_t    load_year,
    input  rtc_time_pkg::month_t   load_month,
    input  rtc_time_pkg::day_t     load_day,
    input  rtc_time_pkg::hour_t    load_hour,
    input  rtc_time_pkg::minute_t  load_minute,
    input  rtc_time_pkg::second_t  load_second,
    input  rtc_time_pkg::weekday_t load_weekday,
    output rtc_time_pkg::year_t    year,
    output rtc_time_pkg::month_t   month,
    output rtc_time_pkg::day_t     day,
    output rtc_time_pkg::hour_t    hour,
    output rtc_time_pkg::minute_t  minute,
    output rtc_time_pkg::second_t  second,
    output rtc_time_pkg::weekday_t weekday
);

    logic minute_carry;
    logic hour_carry;
    logic day_carry;
    logic month_carry;
    logic year_carry;

    rtc_time_pkg::year_t    year_next;
    rtc_time_pkg::month_t   month_next;
    rtc_time_pkg::day_t     day_next;
    rtc_time_pkg::hour_t    hour_next;
    rtc_time_pkg::minute_t  minute_next;
    rtc_time_pkg::second_t  second_next;
    rtc_time_pkg::weekday_t weekday_next;

    // each carry is the one below it plus this field sitting at its last value
    always_comb
    begin
        minute_carry = (second == 6'd59);
        hour_carry   = minute_carry && (minute == 6'd59);
        day_carry    = hour_carry && (hour == 5'd23);
        month_carry  = day_carry && (day == rtc_time_pkg::days_in_month(month, year));
        year_carry   = month_carry && (month == 4'd12);

        second_next  = minute_carry ? 6'd0 : second + 6'd1;
        minute_next  = minute;
        hour_next    = hour;
        day_next     = day;
        weekday_next = weekday;
        month_next   = month;
        year_next    = year;
        if (minute_carry)
        begin
            minute_next = hour_carry ? 6'd0 : minute + 6'd1;
        end
        if (hour_carry)
        begin
            hour_next = day_carry ? 5'd0 : hour + 5'd1;
        end
        if (day_carry)
        begin
            day_next = month_carry ? 5'd1 : day + 5'd1;
            if (weekday == rtc_time_pkg::weekday_last)
            begin
                weekday_next = rtc_time_pkg::weekday_first;
            end
            else
            begin
                weekday_next = weekday + 3'd1;
            end
        end
        if (month_carry)
        begin
            month_next = year_carry ? 4'd1 : month + 4'd1;
        end
        if (year_carry)
        begin
            year_next = year + 16'd1;
        end
    end

    always_ff @(posedge secclk)
    begin
        if (reset)
        begin
            year    <= reset_year;
            month   <= reset_month;
            day     <= reset_day;
            hour    <= reset_hour;
            minute  <= reset_minute;
            second  <= reset_second;
            weekday <= reset_weekday;
        end
        else if (load_strobe)
        begin
            year    <= load_year;
            month   <= load_month;
            day     <= load_day;
            hour    <= load_hour;
            minute  <= load_minute;
            second  <= load_second;
            weekday <= load_weekday;
        end
        else
        begin
            year    <= year_next;
            month   <= month_next;
            day     <= day_next;
            hour    <= hour_next;
            minute  <= minute_next;
            second  <= second_next;
            weekday <= weekday_next;
        end
    end

endmodule

// ==== design/rtc_cmd_decode.sv ====
`timescale 1ns/1ps

module rtc_cmd_decode #(
    parameter rtc_time_pkg::year_t    reset_year    = 16'd2023,
    parameter rtc_time_pkg::month_t   reset_month   = 4'd5,
    parameter rtc_time_pkg::day_t     reset_day     = 5'd9,
    parameter rtc_time_pkg::hour_t    reset_hour    = 5'd11,
    parameter rtc_time_pkg::minute_t  reset_minute  = 6'd59,
    parameter rtc_time_pkg::second_t  reset_second  = 6'd58,
    parameter rtc_time_pkg::weekday_t reset_weekday = 3'd2
) (
    input  logic                   secclk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  rtc_cmd_pkg::cmd_op_t   cmd_op,
    input  rtc_cmd_pkg::cmd_data_t cmd_data,
    output logic                   load_strobe,
    output rtc_time_pkg::year_t    load_year,
    output rtc_time_pkg::month_t   load_month,
    output rtc_time_pkg::day_t     load_day,
    output rtc_time_pkg::hour_t    load_hour,
    output rtc_time_pkg::minute_t  load_minute,
    output rtc_time_pkg::second_t  load_second,
    output rtc_time_pkg::weekday_t load_weekday,
    output logic                   alarm_hour_wr,
    output logic                   alarm_minute_wr,
    output logic                   alarm_en_wr,
    output rtc_cmd_pkg::cmd_data_t alarm_data,
    output logic                   cmd_error
);

    rtc_cmd_pkg::decode_state_t state;
    logic                       commit_ok;
    logic                       field_write;

    // the load_* registers double as the staging copy of the calendar
    always_comb
    begin
        commit_ok = (load_month >= 4'd1) && (load_month <= 4'd12) &&
                    (load_day >= 5'd1) &&
                    (load_day <= rtc_time_pkg::days_in_month(load_month, load_year)) &&
                    (load_hour <= 5'd23) && (load_minute <= 6'd59) &&
                    (load_second <= 6'd59) &&
                    (load_weekday >= rtc_time_pkg::weekday_first) &&
                    (load_weekday <= rtc_time_pkg::weekday_last);
        field_write = cmd_valid && (cmd_op <= rtc_cmd_pkg::op_set_weekday);
    end

    always_ff @(posedge secclk)
    begin
        if (reset)
        begin
            state           <= rtc_cmd_pkg::st_idle;
            load_year       <= reset_year;
            load_month      <= reset_month;
            load_day        <= reset_day;
            load_hour       <= reset_hour;
            load_minute     <= reset_minute;
            load_second     <= reset_second;
            load_weekday    <= reset_weekday;
            load_strobe     <= 1'b0;
            cmd_error       <= 1'b0;
            alarm_hour_wr   <= 1'b0;
            alarm_minute_wr <= 1'b0;
            alarm_en_wr     <= 1'b0;
        end
        else
        begin
            load_strobe     <= 1'b0;
            cmd_error       <= 1'b0;
            alarm_hour_wr   <= 1'b0;
            alarm_minute_wr <= 1'b0;
            alarm_en_wr     <= 1'b0;
            if (field_write)
            begin
                state <= rtc_cmd_pkg::st_staged;
            end
            if (cmd_valid)
            begin
                case (cmd_op)
                    rtc_cmd_pkg::op_set_year:    load_year    <= cmd_data;
                    rtc_cmd_pkg::op_set_month:   load_month   <= rtc_time_pkg::month_t'(cmd_data);
                    rtc_cmd_pkg::op_set_day:     load_day     <= rtc_time_pkg::day_t'(cmd_data);
                    rtc_cmd_pkg::op_set_hour:    load_hour    <= rtc_time_pkg::hour_t'(cmd_data);
                    rtc_cmd_pkg::op_set_minute:  load_minute  <= rtc_time_pkg::minute_t'(cmd_data);
                    rtc_cmd_pkg::op_set_second:  load_second  <= rtc_time_pkg::second_t'(cmd_data);
                    rtc_cmd_pkg::op_set_weekday:
                    begin
                        load_weekday <= rtc_time_pkg::weekday_t'(cmd_data);
                    end
                    rtc_cmd_pkg::op_commit:
                    begin
                        // a commit with nothing staged would rewind the clock to a stale value
                        if (state == rtc_cmd_pkg::st_staged)
                        begin
                            load_strobe <= commit_ok;
                            cmd_error   <= !commit_ok;
                            state       <= rtc_cmd_pkg::st_idle;
                        end
                    end
                    rtc_cmd_pkg::op_set_alarm_hour:   alarm_hour_wr   <= 1'b1;
                    rtc_cmd_pkg::op_set_alarm_minute: alarm_minute_wr <= 1'b1;
                    rtc_cmd_pkg::op_alarm_enable,
                    rtc_cmd_pkg::op_alarm_disable:    alarm_en_wr     <= 1'b1;
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // enable and disable share one strobe, so bit 0 of the data carries which one it was
    always_ff @(posedge secclk)
    begin
        if (cmd_valid)
        begin
            if (cmd_op == rtc_cmd_pkg::op_alarm_enable || cmd_op == rtc_cmd_pkg::op_alarm_disable)
            begin
                alarm_data <= {15'd0, cmd_op == rtc_cmd_pkg::op_alarm_enable};
            end
            else
            begin
                alarm_data <= cmd_data;
            end
        end
    end

endmodule

// ==== design/rtc_cmd_pkg.sv ====
package rtc_cmd_pkg;

    typedef enum logic [3:0] {
        op_set_year         = 4'd0,
        op_set_month        = 4'd1,
        op_set_day          = 4'd2,
        op_set_hour         = 4'd3,
        op_set_minute       = 4'd4,
        op_set_second       = 4'd5,
        op_set_weekday      = 4'd6,
        op_commit           = 4'd7,
        op_set_alarm_hour   = 4'd8,
        op_set_alarm_minute = 4'd9,
        op_alarm_enable     = 4'd10,
        op_alarm_disable    = 4'd11
    } cmd_op_t;

    typedef logic [15:0] cmd_data_t;

    // staged means at least one field was written since the last commit
    typedef enum logic {
        st_idle   = 1'b0,
        st_staged = 1'b1
    } decode_state_t;

endpackage

// ==== design/rtc_time_pkg.sv ====
package rtc_time_pkg;

    typedef logic [15:0] year_t;
    typedef logic [3:0]  month_t;
    typedef logic [4:0]  day_t;
    typedef logic [4:0]  hour_t;
    typedef logic [5:0]  minute_t;
    typedef logic [5:0]  second_t;
    typedef logic [2:0]  weekday_t;

    // weekday counts 1 to 7 and wraps back to 1
    localparam weekday_t weekday_first = 3'd1;
    localparam weekday_t weekday_last  = 3'd7;

    // gregorian rule: every fourth year, but centuries only when divisible by 400
    function automatic logic is_leap(input year_t y);
        logic div4;
        logic div100;
        logic div400;
        div4   = (y % 16'd4) == 16'd0;
        div100 = (y % 16'd100) == 16'd0;
        div400 = (y % 16'd400) == 16'd0;
        return div4 && (!div100 || div400);
    endfunction

    function automatic day_t days_in_month(input month_t m, input year_t y);
        day_t days;
        case (m)
            4'd2:
            begin
                days = is_leap(y) ? 5'd29 : 5'd28;
            end
            4'd4, 4'd6, 4'd9, 4'd11:
            begin
                days = 5'd30;
            end
            default:
            begin
                days = 5'd31;
            end
        endcase
        return days;
    endfunction

endpackage

// ==== design/rtc_top.sv ====
`timescale 1ns/1ps

module rtc_top #(
    parameter rtc_time_pkg::year_t    reset_year    = 16'd2023,
    parameter rtc_time_pkg::month_t   reset_month   = 4'd5,
    parameter rtc_time_pkg::day_t     reset_day     = 5'd9,
    parameter rtc_time_pkg::hour_t    reset_hour    = 5'd11,
    parameter rtc_time_pkg::minute_t  reset_minute  = 6'd59,
    parameter rtc_time_pkg::second_t  reset_second  = 6'd58,
    parameter rtc_time_pkg::weekday_t reset_weekday = 3'd2
) (
    input  logic                   secclk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  rtc_cmd_pkg::cmd_op_t   cmd_op,
    input  rtc_cmd_pkg::cmd_data_t cmd_data,
    output rtc_time_pkg::year_t    year,
    output rtc_time_pkg::month_t   month,
    output rtc_time_pkg::day_t     day,
    output rtc_time_pkg::hour_t    hour,
    output rtc_time_pkg::minute_t  minute,
    output rtc_time_pkg::second_t  second,
    output rtc_time_pkg::weekday_t weekday,
    output logic                   alarm,
    output logic                   cmd_error
);

    logic                   load_strobe;
    rtc_time_pkg::year_t    load_year;
    rtc_time_pkg::month_t   load_month;
    rtc_time_pkg::day_t     load_day;
    rtc_time_pkg::hour_t    load_hour;
    rtc_time_pkg::minute_t  load_minute;
    rtc_time_pkg::second_t  load_second;
    rtc_time_pkg::weekday_t load_weekday;
    logic                   alarm_hour_wr;
    logic                   alarm_minute_wr;
    logic                   alarm_en_wr;
    rtc_cmd_pkg::cmd_data_t alarm_data;

    rtc_cmd_decode #(
        .reset_year    (reset_year),
        .reset_month   (reset_month),
        .reset_day     (reset_day),
        .reset_hour    (reset_hour),
        .reset_minute  (reset_minute),
        .reset_second  (reset_second),
        .reset_weekday (reset_weekday)
    ) u_decode (
        .secclk          (secclk),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd_op          (cmd_op),
        .cmd_data        (cmd_data),
        .load_strobe     (load_strobe),
        .load_year       (load_year),
        .load_month      (load_month),
        .load_day        (load_day),
        .load_hour       (load_hour),
        .load_minute     (load_minute),
        .load_second     (load_second),
        .load_weekday    (load_weekday),
        .alarm_hour_wr   (alarm_hour_wr),
        .alarm_minute_wr (alarm_minute_wr),
        .alarm_en_wr     (alarm_en_wr),
        .alarm_data      (alarm_data),
        .cmd_error       (cmd_error)
    );

    rtc_calendar_counter #(
        .reset_year    (reset_year),
        .reset_month   (reset_month),
        .reset_day     (reset_day),
        .reset_hour    (reset_hour),
        .reset_minute  (reset_minute),
        .reset_second  (reset_second),
        .reset_weekday (reset_weekday)
    ) u_counter (
        .secclk       (secclk),
        .reset        (reset),
        .load_strobe  (load_strobe),
        .load_year    (load_year),
        .load_month   (load_month),
        .load_day     (load_day),
        .load_hour    (load_hour),
        .load_minute  (load_minute),
        .load_second  (load_second),
        .load_weekday (load_weekday),
        .year         (year),
        .month        (month),
        .day          (day),
        .hour         (hour),
        .minute       (minute),
        .second       (second),
        .weekday      (weekday)
    );

    rtc_alarm_match u_alarm (
        .secclk          (secclk),
        .reset           (reset),
        .alarm_hour_wr   (alarm_hour_wr),
        .alarm_minute_wr (alarm_minute_wr),
        .alarm_en_wr     (alarm_en_wr),
        .alarm_data      (alarm_data),
        .hour            (hour),
        .minute          (minute),
        .second          (second),
        .alarm           (alarm)
    );

endmodule

// ==== dv/rtc_tb.sv ====
`timescale 1ns/1ps

module rtc_tb;

    localparam int commit_cycles = 16;
    localparam int random_dates  = 5;
    localparam int random_run    = 100;
    localparam int alarm_window  = 200;
    // reset, then the five tests in the order they run
    localparam int test_cycles   = 5 + 2 +
                                   8 * (commit_cycles + 2) +
                                   (commit_cycles + 2) +
                                   random_dates * (commit_cycles + random_run) +
                                   2 * commit_cycles + 4 +
                                   commit_cycles + 6 + alarm_window +
                                   2 + commit_cycles + 30;
    localparam int margin        = 500;

    logic                   secclk;
    logic                   reset;
    logic                   cmd_valid;
    rtc_cmd_pkg::cmd_op_t   cmd_op;
    rtc_cmd_pkg::cmd_data_t cmd_data;
    rtc_time_pkg::year_t    year;
    rtc_time_pkg::month_t   month;
    rtc_time_pkg::day_t     day;
    rtc_time_pkg::hour_t    hour;
    rtc_time_pkg::minute_t  minute;
    rtc_time_pkg::second_t  second;
    rtc_time_pkg::weekday_t weekday;
    logic                   alarm;
    logic                   cmd_error;

    // reference model state, kept as int so a rollover past the field width is still seen
    int m_year, m_month, m_day, m_hour, m_minute, m_second, m_weekday;
    int s_year, s_month, s_day, s_hour, s_minute, s_second, s_weekday;
    int m_al_hour, m_al_minute, al_val;
    bit m_al_en, staged, load_pend, exp_err, exp_alarm, check_en;
    bit pend_hour, pend_minute, pend_en, pend_en_val;
    int fail_count;
    int tests_passed;
    int tests_failed;
    logic [31:0] rng;

    rtc_top u_dut (
        .secclk    (secclk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_data  (cmd_data),
        .year      (year),
        .month     (month),
        .day       (day),
        .hour      (hour),
        .minute    (minute),
        .second    (second),
        .weekday   (weekday),
        .alarm     (alarm),
        .cmd_error (cmd_error)
    );

    always #50 secclk = ~secclk;

    function automatic bit leap_year(input int y);
        if (y % 400 == 0)
            return 1'b1;
        if (y % 100 == 0)
            return 1'b0;
        return (y % 4 == 0);
    endfunction

    function automatic int month_days(input int m, input int y);
        if (m == 2)
            return leap_year(y) ? 29 : 28;
        if (m == 4 || m == 6 || m == 9 || m == 11)
            return 30;
        return 31;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit staged_valid();
        return s_month >= 1 && s_month <= 12 && s_day >= 1 &&
               s_day <= month_days(s_month, s_year) && s_hour <= 23 &&
               s_minute <= 59 && s_second <= 59 && s_weekday >= 1 && s_weekday <= 7;
    endfunction

    function automatic string format_time(input int y, input int mo, input int d,
                                          input int h, input int mi, input int s,
                                          input int wd);
        return $sformatf("%0d-%0d-%0d %0d:%0d:%0d wd %0d", y, mo, d, h, mi, s, wd);
    endfunction

    always @(posedge secclk)
    begin
        check_en <= !reset;
        if (reset)
        begin
            m_year = 2023;
            m_month = 5;
            m_day = 9;
            m_hour = 11;
            m_minute = 59;
            m_second = 58;
            m_weekday = 2;
            s_year = 2023;
            s_month = 5;
            s_day = 9;
            s_hour = 11;
            s_minute = 59;
            s_second = 58;
            s_weekday = 2;
            m_al_en = 0;
            m_al_hour = 0;
            m_al_minute = 0;
            {staged, load_pend, exp_err, exp_alarm} = 4'b0;
            {pend_hour, pend_minute, pend_en} = 3'b0;
        end
        else
        begin
            exp_alarm = m_al_en && m_hour == m_al_hour && m_minute == m_al_minute &&
                        m_second == 0;
            if (pend_hour)
                m_al_hour = al_val % 32;
            if (pend_minute)
                m_al_minute = al_val % 64;
            if (pend_en)
                m_al_en = pend_en_val;
            if (load_pend)
            begin
                m_year = s_year;
                m_month = s_month;
                m_day = s_day;
                m_hour = s_hour;
                m_minute = s_minute;
                m_second = s_second;
                m_weekday = s_weekday;
            end
            else
            begin
                m_second++;
                if (m_second == 60)
                begin
                    m_second = 0;
                    m_minute++;
                end
                if (m_minute == 60)
                begin
                    m_minute = 0;
                    m_hour++;
                end
                if (m_hour == 24)
                begin
                    m_hour = 0;
                    m_day++;
                    m_weekday = (m_weekday == 7) ? 1 : m_weekday + 1;
                end
                if (m_day > month_days(m_month, m_year))
                begin
                    m_day = 1;
                    m_month++;
                end
                if (m_month == 13)
                begin
                    m_month = 1;
                    m_year++;
                end
            end
            {load_pend, exp_err, pend_hour, pend_minute, pend_en} = 5'b0;
            if (cmd_valid)
            begin
                al_val = cmd_data;
                case (cmd_op)
                    rtc_cmd_pkg::op_set_year:    s_year = cmd_data;
                    rtc_cmd_pkg::op_set_month:   s_month = cmd_data[3:0];
                    rtc_cmd_pkg::op_set_day:     s_day = cmd_data[4:0];
                    rtc_cmd_pkg::op_set_hour:    s_hour = cmd_data[4:0];
                    rtc_cmd_pkg::op_set_minute:  s_minute = cmd_data[5:0];
                    rtc_cmd_pkg::op_set_second:  s_second = cmd_data[5:0];
                    rtc_cmd_pkg::op_set_weekday: s_weekday = cmd_data[2:0];
                    rtc_cmd_pkg::op_set_alarm_hour:   pend_hour = 1;
                    rtc_cmd_pkg::op_set_alarm_minute: pend_minute = 1;
                    rtc_cmd_pkg::op_alarm_enable:     {pend_en, pend_en_val} = 2'b11;
                    rtc_cmd_pkg::op_alarm_disable:    {pend_en, pend_en_val} = 2'b10;
                    default:
                    begin
                    end
                endcase
                if (cmd_op <= rtc_cmd_pkg::op_set_weekday)
                    staged = 1;
                if (cmd_op == rtc_cmd_pkg::op_commit && staged)
                begin
                    load_pend = staged_valid();
                    exp_err = !staged_valid();
                    staged = 0;
                end
            end
        end
    end

    // outputs are registered, so they are stable at the falling edge
    always @(negedge secclk)
    begin
        if (check_en)
        begin
            assert (year == m_year && month == m_month && day == m_day && hour == m_hour &&
                    minute == m_minute && second == m_second && weekday == m_weekday)
            else
            begin
                $display("[FAIL] %0t ns: time %s, model %s", $time,
                         format_time(year, month, day, hour, minute, second, weekday),
                         format_time(m_year, m_month, m_day, m_hour, m_minute, m_second,
                                     m_weekday));
                fail_count++;
            end
            assert (cmd_error == exp_err)
            else
            begin
                $display("[FAIL] %0t ns: cmd_error %b, expected %b", $time, cmd_error, exp_err);
                fail_count++;
            end
            assert (alarm == exp_alarm)
            else
            begin
                $display("[FAIL] %0t ns: alarm %b, expected %b", $time, alarm, exp_alarm);
                fail_count++;
            end
        end
    end

    task automatic require(input bit cond, input string msg);
        assert (cond)
        else
        begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            fail_count++;
        end
    endtask

    task automatic send_cmd(input rtc_cmd_pkg::cmd_op_t op, input int data);
        @(negedge secclk);
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_data = data[15:0];
        @(negedge secclk);
        cmd_valid = 1'b0;
    endtask

    // returns at the falling edge right after the commit edge
    task automatic commit_time(input int y, input int mo, input int d, input int h,
                               input int mi, input int s, input int wd);
        send_cmd(rtc_cmd_pkg::op_set_year, y);
        send_cmd(rtc_cmd_pkg::op_set_month, mo);
        send_cmd(rtc_cmd_pkg::op_set_day, d);
        send_cmd(rtc_cmd_pkg::op_set_hour, h);
        send_cmd(rtc_cmd_pkg::op_set_minute, mi);
        send_cmd(rtc_cmd_pkg::op_set_second, s);
        send_cmd(rtc_cmd_pkg::op_set_weekday, wd);
        send_cmd(rtc_cmd_pkg::op_commit, 0);
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (fail_count == errors_before)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, fail_count - errors_before);
        end
    endtask

    initial
    begin
        #((test_cycles + margin) * 100);
        $display("timeout: the tests did not finish in %0d cycles", test_cycles + margin);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int start;
        int years[4];
        bit leaps[4];
        int y, mo, d;
        bit seen;
        secclk = 1'b0;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = rtc_cmd_pkg::op_set_year;
        cmd_data = '0;
        fail_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        rng = 32'h1afaf5e5;
        years = '{2024, 2023, 2100, 2000};
        leaps = '{1'b1, 1'b0, 1'b0, 1'b1};
        repeat (5) @(negedge secclk);
        reset = 1'b0;

        start = fail_count;
        require(year == 2023 && month == 5 && day == 9 && hour == 11 && minute == 59 &&
                second == 58 && weekday == 2, "reset time is wrong");
        repeat (2) @(negedge secclk);
        require(hour == 12 && minute == 0 && second == 0, "no rollover to 12:00:00");
        end_test("reset_advance", start);

        start = fail_count;
        for (int i = 0; i < 4; i++)
        begin
            for (int fd = 28; fd <= 29; fd++)
            begin
                commit_time(years[i], 2, fd, 23, 59, 59, 3);
                require(cmd_error == (fd == 29 && !leaps[i]),
                        "Feb commit accepted or rejected against the leap rule");
                repeat (2) @(negedge secclk);
                // a rejected Feb 29 leaves the clock running on from the Mar 1 just reached
                if (fd == 28 && leaps[i])
                    require(month == 2 && day == 29, "leap year skipped Feb 29");
                else
                    require(month == 3 && day == 1, "February did not roll into March");
            end
        end
        end_test("leap_years", start);

        start = fail_count;
        commit_time(2023, 12, 31, 23, 59, 59, 7);
        repeat (2) @(negedge secclk);
        require(year == 2024 && month == 1 && day == 1 && weekday == 1 && hour == 0,
                "year end or weekday wrap is wrong");
        for (int n = 0; n < random_dates; n++)
        begin
            rng = xorshift32(rng);
            y = 1900 + rng % 500;
            rng = xorshift32(rng);
            mo = 1 + rng % 12;
            rng = xorshift32(rng);
            d = 1 + rng % month_days(mo, y);
            rng = xorshift32(rng);
            commit_time(y, mo, d, rng % 24, (rng >> 8) % 60, (rng >> 16) % 60,
                        1 + (rng >> 24) % 7);
            repeat (random_run) @(negedge secclk);
        end
        end_test("year_end_random", start);

        start = fail_count;
        commit_time(2023, 4, 31, 10, 0, 0, 1);
        require(cmd_error == 1'b1, "Apr 31 commit raised no error");
        @(negedge secclk);
        require(cmd_error == 1'b0, "cmd_error longer than one cycle");
        commit_time(2023, 2, 29, 10, 0, 0, 1);
        require(cmd_error == 1'b1, "Feb 29 2023 commit raised no error");
        repeat (3) @(negedge secclk);
        end_test("invalid_commit", start);

        start = fail_count;
        commit_time(2022, 6, 15, 8, 58, 0, 3);
        send_cmd(rtc_cmd_pkg::op_set_alarm_hour, 9);
        send_cmd(rtc_cmd_pkg::op_set_alarm_minute, 0);
        send_cmd(rtc_cmd_pkg::op_alarm_enable, 0);
        seen = 0;
        for (int c = 0; c < alarm_window && !seen; c++)
        begin
            @(negedge secclk);
            seen = alarm;
        end
        if (!seen)
        begin
            $display("alarm never fired within %0d cycles", alarm_window);
            fail_count++;
        end
        else
            require(hour == 9 && minute == 0 && second == 1, "alarm at the wrong time");
        send_cmd(rtc_cmd_pkg::op_alarm_disable, 0);
        commit_time(2022, 6, 15, 8, 59, 50, 3);
        seen = 0;
        repeat (30)
        begin
            @(negedge secclk);
            seen = seen | alarm;
        end
        require(!seen, "alarm fired while disabled");
        end_test("alarm", start);

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
